/* verilog/ifd_params.svh */
// Fixed widths, depths, write windows and credit counts, included by every fetch/decode source
`ifndef IFD_PARAMS_SVH
`define IFD_PARAMS_SVH

`define IFD_WORD_W        32
`define IFD_ADDR_W        12

// Instruction format, opcode at the top, then D, A and B
`define IFD_OPCODE_W      4
`define IFD_D_W           10
`define IFD_A_W           9
`define IFD_B_W           9

`define IFD_THREADS       8
`define IFD_THREAD_W      3

`define IFD_IM_DEPTH      256
`define IFD_IM_ADDR_W     8

// Opcode decoder address is the thread number above the opcode
`define IFD_OD_W          20
`define IFD_OD_ADDR_W     7

`define IFD_IM_BASE       12'h400
`define IFD_OD_BASE       12'h800
`define IFD_DB_BASE       10'd512

`define IFD_WRITE_RETIME  1
`define IFD_QUEUE_DEPTH   4
`define IFD_OUT_CREDITS   2

`endif

/* verilog/ifd_pkg.sv */
// Shared width typedefs and bundle structs for the fetch/decode subsystem, referenced by scope
`default_nettype none

`include "ifd_params.svh"

package ifd_pkg;

    // ----------------------------------------------------------------------
    // Vectors with a meaning of their own

    typedef logic [`IFD_WORD_W-1:0]    word_t;
    typedef logic [`IFD_ADDR_W-1:0]    addr_t;
    typedef logic [`IFD_OPCODE_W-1:0]  opcode_t;
    typedef logic [`IFD_D_W-1:0]       d_operand_t;
    typedef logic [`IFD_A_W-1:0]       a_operand_t;
    typedef logic [`IFD_B_W-1:0]       b_operand_t;
    typedef logic [`IFD_THREAD_W-1:0]  thread_t;
    typedef logic [`IFD_IM_ADDR_W-1:0] im_addr_t;
    typedef logic [`IFD_OD_ADDR_W-1:0] od_addr_t;
    typedef logic [`IFD_OD_W-1:0]      alu_control_t;

    // ----------------------------------------------------------------------
    // Port bundles

    // One write from the processor's write address space
    typedef struct packed {
        logic  ior;
        logic  cancel;
        addr_t addr;
        word_t data;
    } wr_req_t;

    typedef struct packed {
        thread_t  thread;
        im_addr_t pc;
    } fetch_req_t;

    // What the consumer receives for each fetch
    typedef struct packed {
        thread_t      thread;
        alu_control_t alu_control;
        d_operand_t   da;
        d_operand_t   db;
        a_operand_t   a;
        b_operand_t   b;
    } decoded_t;

endpackage

`default_nettype wire

/* verilog/write_mapper.sv */
// Qualifies and retimes processor writes, then maps them onto the IM and OD write windows
`default_nettype none

`include "ifd_params.svh"

module write_mapper (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   wr_valid,
    input  wire ifd_pkg::wr_req_t wr_req,
    output logic                  im_wren,
    output ifd_pkg::im_addr_t     im_waddr,
    output logic                  od_wren,
    output ifd_pkg::od_addr_t     od_waddr,
    output ifd_pkg::word_t        wdata
);

    logic                         instruction_ok;
    logic [`IFD_WRITE_RETIME-1:0] ok_pipe;
    ifd_pkg::addr_t               addr_pipe [`IFD_WRITE_RETIME];
    ifd_pkg::word_t               data_pipe [`IFD_WRITE_RETIME];
    ifd_pkg::addr_t               addr_rt;
    ifd_pkg::addr_t               im_offset;
    ifd_pkg::addr_t               od_offset;
    logic                         im_hit;
    logic                         od_hit;

    // A cancelled or never-issued instruction must not write anything
    assign instruction_ok = wr_valid && wr_req.ior && !wr_req.cancel;

    // ----------------------------------------------------------------------
    // Retiming delay line

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ok_pipe <= '0;
        end else begin
            ok_pipe[0] <= instruction_ok;
            for (int i = 1; i < `IFD_WRITE_RETIME; i++) begin
                ok_pipe[i] <= ok_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        addr_pipe[0] <= wr_req.addr;
        data_pipe[0] <= wr_req.data;
        for (int i = 1; i < `IFD_WRITE_RETIME; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign addr_rt = addr_pipe[`IFD_WRITE_RETIME-1];
    assign wdata   = data_pipe[`IFD_WRITE_RETIME-1];

    // ----------------------------------------------------------------------
    // Window decode, the two windows do not overlap

    assign im_offset = addr_rt - `IFD_IM_BASE;
    assign od_offset = addr_rt - `IFD_OD_BASE;

    assign im_hit = (addr_rt >= `IFD_IM_BASE) && (addr_rt < `IFD_IM_BASE + `IFD_IM_DEPTH);
    assign od_hit = (addr_rt >= `IFD_OD_BASE)
                 && (addr_rt < `IFD_OD_BASE + (1 << `IFD_OD_ADDR_W));

    assign im_wren  = ok_pipe[`IFD_WRITE_RETIME-1] && im_hit;
    assign od_wren  = ok_pipe[`IFD_WRITE_RETIME-1] && od_hit;
    assign im_waddr = im_offset[`IFD_IM_ADDR_W-1:0];
    assign od_waddr = od_offset[`IFD_OD_ADDR_W-1:0];

endmodule

`default_nettype wire

/* verilog/instr_mem.sv */
// Shared instruction memory with one write port and a gated registered read port
`default_nettype none

`include "ifd_params.svh"

module instr_mem (
    input  wire                    clock,
    input  wire                    im_wren,
    input  wire ifd_pkg::im_addr_t im_waddr,
    input  wire ifd_pkg::word_t    wdata,
    input  wire                    rden,
    input  wire ifd_pkg::im_addr_t raddr,
    output ifd_pkg::word_t         rdata
);

    ifd_pkg::word_t mem [`IFD_IM_DEPTH];

    // ----------------------------------------------------------------------
    // Write port

    always_ff @(posedge clock) begin
        if (im_wren) begin
            mem[im_waddr] <= wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read port

    // A disabled read yields an all-zero word, which decodes as a NOP.
    // On an address collision the old contents are returned
    always_ff @(posedge clock) begin
        if (rden) begin
            rdata <= mem[raddr];
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/opcode_decoder_mem.sv */
// Per-thread opcode decoder memory that turns thread and opcode into an ALU control word
`default_nettype none

`include "ifd_params.svh"

module opcode_decoder_mem (
    input  wire                    clock,
    input  wire                    od_wren,
    input  wire ifd_pkg::od_addr_t od_waddr,
    input  wire ifd_pkg::word_t    wdata,
    input  wire                    rden,
    input  wire ifd_pkg::thread_t  thread,
    input  wire ifd_pkg::opcode_t  opcode,
    output ifd_pkg::alu_control_t  alu_control
);

    ifd_pkg::alu_control_t mem [1 << `IFD_OD_ADDR_W];
    ifd_pkg::od_addr_t     raddr;

    // Each thread owns a contiguous slice indexed by opcode
    assign raddr = {thread, opcode};

    // ----------------------------------------------------------------------
    // Write port

    // Only the low bits of the data word hold the control word
    always_ff @(posedge clock) begin
        if (od_wren) begin
            mem[od_waddr] <= wdata[`IFD_OD_W-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Read port

    always_ff @(posedge clock) begin
        if (rden) begin
            alu_control <= mem[raddr];
        end else begin
            alu_control <= '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_decode.sv */
// Two-stage fetch and decode pipeline from fetch request to decoded instruction
`default_nettype none

`include "ifd_params.svh"

module fetch_decode (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       fetch_valid,
    input  wire ifd_pkg::fetch_req_t  fetch_req,
    input  wire                       im_wren,
    input  wire ifd_pkg::im_addr_t    im_waddr,
    input  wire                       od_wren,
    input  wire ifd_pkg::od_addr_t    od_waddr,
    input  wire ifd_pkg::word_t       wdata,
    output logic                      dec_valid,
    output ifd_pkg::decoded_t         dec_instr
);

    logic [1:0]            startup_sr;
    logic                  rden;
    logic                  valid_s1;
    logic                  rden_s1;
    ifd_pkg::thread_t      thread_s1;
    ifd_pkg::word_t        instr_s1;
    ifd_pkg::opcode_t      opcode_s1;
    ifd_pkg::d_operand_t   d_s1;
    ifd_pkg::a_operand_t   a_s1;
    ifd_pkg::b_operand_t   b_s1;
    logic                  valid_s2;
    logic                  rden_s2;
    ifd_pkg::thread_t      thread_s2;
    ifd_pkg::alu_control_t alu_control_s2;
    ifd_pkg::d_operand_t   da_s2;
    ifd_pkg::d_operand_t   db_s2;
    ifd_pkg::a_operand_t   a_s2;
    ifd_pkg::b_operand_t   b_s2;

    // ----------------------------------------------------------------------
    // Startup read disable

    // The first two fetches after reset are bogus PCs, so both memories
    // stay read-disabled until the shift register fills
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            startup_sr <= '0;
        end else begin
            startup_sr <= {startup_sr[0], 1'b1};
        end
    end

    assign rden = startup_sr[1];

    // ----------------------------------------------------------------------
    // Stage 1: instruction read and field split

    instr_mem u_instr_mem (
        .clock    (clock),
        .im_wren  (im_wren),
        .im_waddr (im_waddr),
        .wdata    (wdata),
        .rden     (rden),
        .raddr    (fetch_req.pc),
        .rdata    (instr_s1)
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            rden_s1  <= 1'b0;
        end else begin
            valid_s1 <= fetch_valid;
            rden_s1  <= rden;
        end
    end

    always_ff @(posedge clock) begin
        thread_s1 <= fetch_req.thread;
    end

    assign {opcode_s1, d_s1, a_s1, b_s1} = instr_s1;

    // ----------------------------------------------------------------------
    // Stage 2: opcode lookup and operand registers

    opcode_decoder_mem u_opcode_decoder_mem (
        .clock       (clock),
        .od_wren     (od_wren),
        .od_waddr    (od_waddr),
        .wdata       (wdata),
        .rden        (rden_s1),
        .thread      (thread_s1),
        .opcode      (opcode_s1),
        .alu_control (alu_control_s2)
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_s2 <= 1'b0;
            rden_s2  <= 1'b0;
        end else begin
            valid_s2 <= valid_s1;
            rden_s2  <= rden_s1;
        end
    end

    // DB is D rebased into the B operand space
    always_ff @(posedge clock) begin
        thread_s2 <= thread_s1;
        da_s2     <= d_s1;
        db_s2     <= d_s1 - `IFD_DB_BASE;
        a_s2      <= a_s1;
        b_s2      <= b_s1;
    end

    // A NOP still carries its thread, but DB would wrap to non-zero
    always_comb begin
        dec_instr             = '0;
        dec_instr.thread      = thread_s2;
        dec_instr.alu_control = alu_control_s2;
        dec_instr.da          = da_s2;
        dec_instr.db          = rden_s2 ? db_s2 : '0;
        dec_instr.a           = a_s2;
        dec_instr.b           = b_s2;
    end

    assign dec_valid = valid_s2;

endmodule

`default_nettype wire

/* verilog/decode_out_queue.sv */
// Decoded-instruction FIFO with output credit counting and fetch credit return
`default_nettype none

`include "ifd_params.svh"

module decode_out_queue (
    input  wire                      clock,
    input  wire                      rst_n,
    input  wire                      dec_valid,
    input  wire ifd_pkg::decoded_t   dec_instr,
    input  wire                      out_credit,
    output logic                     out_valid,
    output ifd_pkg::decoded_t        out_instr,
    output logic                     fetch_credit
);

    ifd_pkg::decoded_t                        mem [`IFD_QUEUE_DEPTH];
    logic [$clog2(`IFD_QUEUE_DEPTH)-1:0]      wr_ptr;
    logic [$clog2(`IFD_QUEUE_DEPTH)-1:0]      rd_ptr;
    logic [$clog2(`IFD_QUEUE_DEPTH+1)-1:0]    count;
    logic [$clog2(`IFD_OUT_CREDITS+1)-1:0]    credit_cnt;
    logic                                     push;
    logic                                     pop;

    // Overflow cannot happen because upstream holds only as many fetch
    // credits as there are entries
    assign push = dec_valid;
    assign pop  = (count != '0) && (credit_cnt != '0);

    // ----------------------------------------------------------------------
    // Storage

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= dec_instr;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers and occupancy

    // Depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Output credits

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            credit_cnt <= `IFD_OUT_CREDITS;
        end else begin
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Every pop hands a fetch credit back upstream in the same cycle
    assign out_valid    = pop;
    assign fetch_credit = pop;
    assign out_instr    = mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/ifd_mapped_top.sv */
// Top level of the memory-mapped fetch/decode subsystem, instantiated by the testbench as DUT
`default_nettype none

`include "ifd_params.svh"

module ifd_mapped_top (
    input  wire                      clock,
    input  wire                      rst_n,
    input  wire                      wr_valid,
    input  wire ifd_pkg::wr_req_t    wr_req,
    input  wire                      fetch_valid,
    input  wire ifd_pkg::fetch_req_t fetch_req,
    input  wire                      out_credit,
    output logic                     out_valid,
    output ifd_pkg::decoded_t        out_instr,
    output logic                     fetch_credit
);

    logic              im_wren;
    ifd_pkg::im_addr_t im_waddr;
    logic              od_wren;
    ifd_pkg::od_addr_t od_waddr;
    ifd_pkg::word_t    wdata;
    logic              dec_valid;
    ifd_pkg::decoded_t dec_instr;

    // ----------------------------------------------------------------------
    // Write space mapping

    write_mapper u_write_mapper (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_req   (wr_req),
        .im_wren  (im_wren),
        .im_waddr (im_waddr),
        .od_wren  (od_wren),
        .od_waddr (od_waddr),
        .wdata    (wdata)
    );

    // ----------------------------------------------------------------------
    // Fetch, decode and output queue

    fetch_decode u_fetch_decode (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .im_wren     (im_wren),
        .im_waddr    (im_waddr),
        .od_wren     (od_wren),
        .od_waddr    (od_waddr),
        .wdata       (wdata),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr)
    );

    decode_out_queue u_decode_out_queue (
        .clock        (clock),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_instr    (dec_instr),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_instr    (out_instr),
        .fetch_credit (fetch_credit)
    );

endmodule

`default_nettype wire

/* sim/ifd_properties.sv */
// Queue and credit invariants of the decode output queue, bound into every queue instance
`default_nettype none

`include "ifd_params.svh"

module ifd_properties (
    input wire                                  clock,
    input wire                                  rst_n,
    input wire [$clog2(`IFD_QUEUE_DEPTH+1)-1:0] count,
    input wire [$clog2(`IFD_OUT_CREDITS+1)-1:0] credit_cnt,
    input wire                                  push,
    input wire                                  out_credit,
    input wire                                  out_valid,
    input wire                                  fetch_credit
);

    occupancy_bound: assert property (@(posedge clock) disable iff (!rst_n)
        count <= `IFD_QUEUE_DEPTH)
        else $error("queue occupancy above its depth");

    // An exhausted counter stays idle until the consumer returns a credit
    pop_needs_credit: assert property (@(posedge clock) disable iff (!rst_n)
        credit_cnt == '0 && !out_credit |=> !out_valid)
        else $error("out_valid without an output credit");

    // Each returned fetch credit stands for one entry leaving the queue
    pop_returns_credit: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_credit && !push |=> count == $past(count) - 1'b1)
        else $error("fetch credit returned without an entry leaving the queue");

    // With the pipeline empty a full queue cannot see another push
    no_push_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        !(push && count == `IFD_QUEUE_DEPTH))
        else $error("push into a full queue");

endmodule

bind decode_out_queue ifd_properties u_ifd_properties (
    .clock        (clock),
    .rst_n        (rst_n),
    .count        (count),
    .credit_cnt   (credit_cnt),
    .push         (push),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .fetch_credit (fetch_credit)
);

`default_nettype wire

/* sim/ifd_tb.sv */
// Self-checking testbench for the fetch/decode top level with LCG stimulus and a reference model
`default_nettype none

`include "ifd_params.svh"

module ifd_tb;

    logic                clock;
    logic                rst_n;
    logic                wr_valid;
    ifd_pkg::wr_req_t    wr_req;
    logic                fetch_valid;
    ifd_pkg::fetch_req_t fetch_req;
    logic                out_credit;
    logic                out_valid;
    ifd_pkg::decoded_t   out_instr;
    logic                fetch_credit;

    ifd_pkg::word_t        shadow_im [`IFD_IM_DEPTH];
    ifd_pkg::alu_control_t shadow_od [1 << `IFD_OD_ADDR_W];
    ifd_pkg::decoded_t     exp_q [$];
    ifd_pkg::wr_req_t      no_write;
    int unsigned           lcg_state;
    int                    mismatches;
    int                    other_errors;
    int                    fetch_cred;
    int                    out_cred;
    int                    held;
    int                    startup_left;
    int                    issued;
    int                    received;
    int                    fetch_pct;
    int                    credit_pct;
    int                    ready;
    bit [2:0]              issue_pipe;
    bit                    fetch_en;
    bit                    withhold;

    ifd_mapped_top u_ifd_mapped_top (
        .clock        (clock),
        .rst_n        (rst_n),
        .wr_valid     (wr_valid),
        .wr_req       (wr_req),
        .fetch_valid  (fetch_valid),
        .fetch_req    (fetch_req),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_instr    (out_instr),
        .fetch_credit (fetch_credit)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers and reference model

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 9;
    endfunction

    function automatic ifd_pkg::word_t rand_word();
        return ifd_pkg::word_t'({rand_next(), rand_next()});
    endfunction

    function automatic ifd_pkg::wr_req_t random_write();
        ifd_pkg::wr_req_t r;
        int unsigned      sel;
        int               edges [3];
        sel      = rand_next() % 4;
        edges[0] = `IFD_IM_BASE - 1;
        edges[1] = `IFD_IM_BASE + `IFD_IM_DEPTH;
        edges[2] = `IFD_OD_BASE + (1 << `IFD_OD_ADDR_W);
        r.ior    = (rand_next() % 8) != 0;
        r.cancel = (rand_next() % 8) == 0;
        r.data   = rand_word();
        case (sel)
            0:       r.addr = ifd_pkg::addr_t'(`IFD_IM_BASE + rand_next() % `IFD_IM_DEPTH);
            1:       r.addr = ifd_pkg::addr_t'(`IFD_OD_BASE + rand_next() % 128);
            2:       r.addr = ifd_pkg::addr_t'(rand_next());
            default: r.addr = ifd_pkg::addr_t'(edges[rand_next() % 3]);
        endcase
        return r;
    endfunction

    // Opcode on top, then D, A and B; DB is D less the B-space base
    function automatic ifd_pkg::decoded_t expected_decode(input ifd_pkg::thread_t th,
                                                          input ifd_pkg::im_addr_t pc,
                                                          input bit nop);
        ifd_pkg::word_t     w;
        ifd_pkg::opcode_t   op;
        ifd_pkg::d_operand_t d;
        ifd_pkg::decoded_t  r;
        w  = shadow_im[pc];
        op = w[`IFD_WORD_W-1 -: `IFD_OPCODE_W];
        d  = w[`IFD_WORD_W-`IFD_OPCODE_W-1 -: `IFD_D_W];
        r  = '0;
        r.thread = th;
        if (!nop) begin
            r.alu_control = shadow_od[{th, op}];
            r.da          = d;
            r.db          = d - `IFD_DB_BASE;
            r.a           = w[`IFD_A_W+`IFD_B_W-1 -: `IFD_A_W];
            r.b           = w[`IFD_B_W-1:0];
        end
        return r;
    endfunction

    task automatic apply_write(input ifd_pkg::wr_req_t req);
        int a;
        a = req.addr;
        if (req.ior && !req.cancel) begin
            if (a >= `IFD_IM_BASE && a < `IFD_IM_BASE + `IFD_IM_DEPTH) begin
                shadow_im[a - `IFD_IM_BASE] = req.data;
            end
            if (a >= `IFD_OD_BASE && a < `IFD_OD_BASE + (1 << `IFD_OD_ADDR_W)) begin
                shadow_od[a - `IFD_OD_BASE] = req.data[`IFD_OD_W-1:0];
            end
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at time %0t: %s got 0x%h expected 0x%h",
                     $time, what, got, expected);
            mismatches++;
        end
    endtask

    // Outputs are sampled on the falling edge, between the register updates.
    // A fetch becomes poppable three cycles after it was issued
    task automatic observe_outputs();
        bit exp_valid;
        ready     = ready + issue_pipe[2];
        exp_valid = (ready > 0) && (out_cred > 0);
        check_value("out_valid", out_valid, exp_valid);
        check_value("fetch_credit", fetch_credit, exp_valid);
        if (exp_valid) begin
            ready--;
        end
        if (out_valid) begin
            if (out_cred == 0) begin
                $display("Error at time %0t: out_valid while the consumer gave no credit", $time);
                other_errors++;
            end else begin
                out_cred--;
            end
            held++;
            received++;
            if (exp_q.size() == 0) begin
                $display("Error at time %0t: out_valid with no fetch outstanding", $time);
                other_errors++;
            end else begin
                check_value("out_instr", out_instr, exp_q.pop_front());
            end
        end
        if (fetch_credit) begin
            fetch_cred++;
            check_value("fetch credits within queue depth",
                        fetch_cred <= `IFD_QUEUE_DEPTH, 1);
        end
    endtask

    task automatic drive_stream();
        ifd_pkg::fetch_req_t req;
        if (fetch_en && fetch_cred > 0 && (rand_next() % 100) < fetch_pct) begin
            req.thread  = ifd_pkg::thread_t'(rand_next());
            req.pc      = ifd_pkg::im_addr_t'(rand_next());
            fetch_valid = 1'b1;
            fetch_req   = req;
            exp_q.push_back(expected_decode(req.thread, req.pc, startup_left > 0));
            fetch_cred--;
            issued++;
        end else begin
            fetch_valid = 1'b0;
        end
        issue_pipe = {issue_pipe[1:0], fetch_valid};
        if (startup_left > 0) begin
            startup_left--;
        end
        // The consumer frees one held slot at a time
        if (!withhold && held > 0 && (rand_next() % 100) < credit_pct) begin
            out_credit = 1'b1;
            held--;
            out_cred++;
        end else begin
            out_credit = 1'b0;
        end
    endtask

    task automatic cycle_step(input bit do_write, input ifd_pkg::wr_req_t req);
        @(negedge clock);
        observe_outputs();
        wr_valid = do_write;
        if (do_write) begin
            wr_req = req;
            apply_write(req);
        end else begin
            // An idle write port still carries a payload that must be ignored
            wr_req = random_write();
        end
        drive_stream();
    endtask

    // ----------------------------------------------------------------------
    // Test sequence

    initial begin
        int                 wait_cycles;
        int                 rx_before;
        int                 cred_before;
        ifd_pkg::wr_req_t   w;
        lcg_state    = 98146;
        mismatches   = 0;
        other_errors = 0;
        fetch_cred   = `IFD_QUEUE_DEPTH;
        out_cred     = `IFD_OUT_CREDITS;
        held         = 0;
        issued       = 0;
        received     = 0;
        ready        = 0;
        issue_pipe   = '0;
        startup_left = 0;
        withhold     = 1'b0;
        fetch_en     = 1'b0;
        fetch_pct    = 100;
        credit_pct   = 50;
        no_write     = '0;
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr_req       = '0;
        fetch_valid  = 1'b0;
        fetch_req    = '0;
        out_credit   = 1'b0;
        repeat (5) @(posedge clock);

        // Two fetches right after reset decode as NOPs
        @(negedge clock);
        rst_n        = 1'b1;
        startup_left = 2;
        fetch_en     = 1'b1;
        drive_stream();
        cycle_step(1'b0, no_write);
        fetch_en = 1'b0;

        // Fill both memories, then overwrite at random with some misses
        for (int i = 0; i < `IFD_IM_DEPTH; i++) begin
            w = '{ior: 1'b1, cancel: 1'b0,
                  addr: ifd_pkg::addr_t'(`IFD_IM_BASE + i), data: rand_word()};
            cycle_step(1'b1, w);
        end
        for (int i = 0; i < (1 << `IFD_OD_ADDR_W); i++) begin
            w = '{ior: 1'b1, cancel: 1'b0,
                  addr: ifd_pkg::addr_t'(`IFD_OD_BASE + i), data: rand_word()};
            cycle_step(1'b1, w);
        end
        repeat (300) cycle_step(1'b1, random_write());
        repeat (3) cycle_step(1'b0, no_write);

        // Random fetches across all threads
        fetch_en   = 1'b1;
        fetch_pct  = 70;
        credit_pct = 60;
        repeat (400) cycle_step(1'b0, no_write);

        // Consumer stops returning credits
        withhold    = 1'b1;
        rx_before   = received;
        cred_before = out_cred;
        repeat (40) cycle_step(1'b0, no_write);
        check_value("out_valid pulses while withheld", (received - rx_before) <= cred_before, 1);
        check_value("fetch credits left while withheld", fetch_cred, 0);
        withhold = 1'b0;

        // Sustained run at full fetch rate
        fetch_pct  = 100;
        credit_pct = 50;
        repeat (500) cycle_step(1'b0, no_write);

        fetch_en    = 1'b0;
        credit_pct  = 100;
        wait_cycles = 0;
        while (exp_q.size() > 0 && wait_cycles < 200) begin
            cycle_step(1'b0, no_write);
            wait_cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d decoded instructions never came out", exp_q.size());
            other_errors++;
        end else begin
            check_value("fetch credits returned", fetch_cred, `IFD_QUEUE_DEPTH);
            check_value("instructions delivered", received, issued);
        end

        $display("Summary: %0d mismatches, %0d other errors, %0d instructions checked",
                 mismatches, other_errors, received);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/ifd_pkg.sv
verilog/write_mapper.sv
verilog/instr_mem.sv
verilog/opcode_decoder_mem.sv
verilog/fetch_decode.sv
verilog/decode_out_queue.sv
verilog/ifd_mapped_top.sv
sim/ifd_properties.sv
sim/ifd_tb.sv
